// ==== verilog/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split into tag, index and byte offset
`define DC_ADDR_W    32
`define DC_INDEX_W   6    // 64 sets
`define DC_OFFSET_W  6    // 64 bytes per line

`define DC_LINE_W    512

// whatever is left above index and offset
`define DC_TAG_W     (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`define DC_WAYS      2

`endif

// ==== verilog/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } dcache_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } dcache_size_e;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        LOOKUP     = 3'd1,
        WRITE_BACK = 3'd2,   // dirty victim out first
        MISS       = 3'd3,
        REFILL     = 3'd4,
        RESPOND    = 3'd5
    } dcache_state_e;

    typedef logic [`DC_LINE_W-1:0] line_t;

    // request as issued by the load/store pipeline
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        dcache_op_e            op;
        dcache_size_e          size;
        logic                  sign;    // sign-extend loads
        logic [31:0]           wdata;   // store value in the low bits
    } dcache_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
        logic                 dirty;
        line_t                line;
        logic                 hit;
    } way_rd_t;

    typedef struct packed {
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_TAG_W-1:0]    tag;
        line_t                   data;
        logic [`DC_LINE_W/8-1:0] be;       // one bit per byte
        logic                    tag_we;   // also sets valid
        logic                    dirty_we;
        logic                    dirty;
    } way_wr_t;

    typedef struct packed {
        line_t                   data;
        logic [`DC_LINE_W/8-1:0] mask;
    } store_t;

    // line read request towards memory
    typedef struct packed {
        logic                  valid;
        logic [`DC_ADDR_W-1:0] addr;
    } mem_rd_t;

endpackage

// ==== verilog/dcache_req_buf.sv ====
`include "dcache_macros.svh"

module dcache_req_buf (
    input  logic                    clk,
    input  logic                    rstn,
    input  dcache_pkg::dcache_req_t i_req,
    input  logic                    i_take,
    output dcache_pkg::dcache_req_t o_req,
    output dcache_pkg::store_t      o_store
);

    localparam int BYTES = `DC_LINE_W / 8;

    dcache_pkg::dcache_req_t req_q;
    logic [`DC_OFFSET_W-1:0] offset;
    logic [3:0]              lane_mask;   // bytes touched within the word

    // request stays put until the controller takes the next one
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q <= '0;
        end else if (i_take) begin
            req_q <= i_req;
        end
    end

    assign o_req  = req_q;
    assign offset = req_q.addr[`DC_OFFSET_W-1:0];

    always_comb begin
        case (req_q.size)
            dcache_pkg::SIZE_BYTE: lane_mask = 4'b0001;
            dcache_pkg::SIZE_HALF: lane_mask = 4'b0011;
            default:               lane_mask = 4'b1111;
        endcase
    end

    // aligned access, so a plain byte shift lands the value in lane and word
    assign o_store.data = dcache_pkg::line_t'(req_q.wdata) << {offset, 3'b000};

    // loads never write the array
    assign o_store.mask = (req_q.op == dcache_pkg::OP_WRITE) ?
                          (BYTES'(lane_mask) << offset) : '0;

endmodule

// ==== verilog/dcache_way.sv ====
`include "dcache_macros.svh"

module dcache_way (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DC_INDEX_W-1:0] i_rd_index,
    input  logic [`DC_TAG_W-1:0]   i_tag,       // tag of the held request
    input  dcache_pkg::way_wr_t    i_wr,
    output dcache_pkg::way_rd_t    o_rd
);

    localparam int SETS  = 1 << `DC_INDEX_W;
    localparam int BYTES = `DC_LINE_W / 8;

    logic [`DC_TAG_W-1:0] tag_mem [SETS];
    dcache_pkg::line_t    data_mem [SETS];
    logic [SETS-1:0]      valid_q;
    logic [SETS-1:0]      dirty_q;

    logic                 rd_valid;
    logic                 rd_dirty;
    logic [`DC_TAG_W-1:0] rd_tag;
    dcache_pkg::line_t    rd_line;

    // valid and dirty bits per set
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (i_wr.tag_we) begin
                valid_q[i_wr.index] <= 1'b1;
            end
            if (i_wr.dirty_we) begin
                dirty_q[i_wr.index] <= i_wr.dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr.tag_we) begin
            tag_mem[i_wr.index] <= i_wr.tag;
        end
    end

    // byte-enabled line write
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (i_wr.be[b]) begin
                data_mem[i_wr.index][b*8 +: 8] <= i_wr.data[b*8 +: 8];
            end
        end
    end

    // synchronous read with the result one cycle after the index
    always_ff @(posedge clk) begin
        rd_valid <= valid_q[i_rd_index];
        rd_dirty <= dirty_q[i_rd_index];
        rd_tag   <= tag_mem[i_rd_index];
        rd_line  <= data_mem[i_rd_index];
    end

    assign o_rd.valid = rd_valid;
    assign o_rd.tag   = rd_tag;
    assign o_rd.dirty = rd_dirty;
    assign o_rd.line  = rd_line;
    assign o_rd.hit   = rd_valid && (rd_tag == i_tag);

endmodule

// ==== verilog/dcache_ctrl.sv ====
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    i_valid,
    input  logic [`DC_INDEX_W-1:0]  i_new_index,   // index of the incoming request
    input  dcache_pkg::dcache_req_t i_req,         // held request
    input  dcache_pkg::store_t      i_store,
    input  dcache_pkg::way_rd_t     i_way_rd [`DC_WAYS],
    output logic                    o_take,
    output logic                    o_accept,
    output logic [`DC_INDEX_W-1:0]  o_rd_index,
    output dcache_pkg::way_wr_t     o_way_wr [`DC_WAYS],
    output logic                    o_use_refill,
    output dcache_pkg::line_t       o_refill_line,
    output logic                    o_done,
    output dcache_pkg::mem_rd_t     o_mem_rd,
    input  logic                    i_mem_rd_ready,
    input  dcache_pkg::line_t       i_mem_rd_data,
    output logic                    o_mem_wr_valid,
    output logic [`DC_ADDR_W-1:0]   o_mem_wr_addr,
    output dcache_pkg::line_t       o_mem_wr_data,
    input  logic                    i_mem_wr_ready
);

    localparam int SETS  = 1 << `DC_INDEX_W;
    localparam int BYTES = `DC_LINE_W / 8;

    dcache_pkg::dcache_state_e state;
    dcache_pkg::dcache_state_e state_nxt;

    logic [SETS-1:0]        lru_q;    // way used last in each set
    dcache_pkg::line_t      ret_q;    // line returned by memory
    dcache_pkg::line_t      merged;
    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_TAG_W-1:0]   tag;
    logic                   is_write;
    logic                   hit_any;
    logic                   hit_way;
    logic                   victim;
    logic                   victim_dirty;

    assign index    = i_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign tag      = i_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign is_write = (i_req.op == dcache_pkg::OP_WRITE);

    always_comb begin
        hit_any = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (i_way_rd[w].hit) begin
                hit_any = 1'b1;
                hit_way = 1'(w);
            end
        end
    end

    assign victim       = ~lru_q[index];
    assign victim_dirty = i_way_rd[victim].valid & i_way_rd[victim].dirty;

    // read hits keep the pipe open while everything else drains first
    assign o_accept   = (state == dcache_pkg::IDLE) ||
                        (state == dcache_pkg::LOOKUP && !is_write && hit_any);
    assign o_take     = i_valid & o_accept;
    assign o_rd_index = o_take ? i_new_index : index;

    assign o_done        = (state == dcache_pkg::LOOKUP && hit_any) ||
                           (state == dcache_pkg::RESPOND);
    assign o_use_refill  = (state == dcache_pkg::RESPOND);
    assign o_refill_line = ret_q;

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (o_take) state_nxt = dcache_pkg::LOOKUP;
            end
            dcache_pkg::LOOKUP: begin
                if (hit_any) begin
                    state_nxt = o_take ? dcache_pkg::LOOKUP : dcache_pkg::IDLE;
                end else begin
                    state_nxt = victim_dirty ? dcache_pkg::WRITE_BACK : dcache_pkg::MISS;
                end
            end
            dcache_pkg::WRITE_BACK: begin
                if (i_mem_wr_ready) state_nxt = dcache_pkg::MISS;
            end
            dcache_pkg::MISS: begin
                if (i_mem_rd_ready) state_nxt = dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL:  state_nxt = dcache_pkg::RESPOND;
            dcache_pkg::RESPOND: state_nxt = dcache_pkg::IDLE;
            default:             state_nxt = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= dcache_pkg::IDLE;
            lru_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == dcache_pkg::LOOKUP && hit_any) begin
                lru_q[index] <= hit_way;
            end else if (state == dcache_pkg::REFILL) begin
                lru_q[index] <= victim;   // refilled way becomes most recent
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::MISS && i_mem_rd_ready) begin
            ret_q <= i_mem_rd_data;
        end
    end

    // store bytes win over the returned line
    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            merged[b*8 +: 8] = i_store.mask[b] ? i_store.data[b*8 +: 8] : ret_q[b*8 +: 8];
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            o_way_wr[w].index    = index;
            o_way_wr[w].tag      = tag;
            o_way_wr[w].data     = (state == dcache_pkg::REFILL) ? merged : i_store.data;
            o_way_wr[w].be       = '0;
            o_way_wr[w].tag_we   = 1'b0;
            o_way_wr[w].dirty_we = 1'b0;
            o_way_wr[w].dirty    = is_write;   // clean refill for loads
            if (state == dcache_pkg::LOOKUP && hit_any && is_write && hit_way == 1'(w)) begin
                o_way_wr[w].be       = i_store.mask;
                o_way_wr[w].dirty_we = 1'b1;
            end
            if (state == dcache_pkg::REFILL && victim == 1'(w)) begin
                o_way_wr[w].be       = '1;
                o_way_wr[w].tag_we   = 1'b1;
                o_way_wr[w].dirty_we = 1'b1;
            end
        end
    end

    assign o_mem_rd.valid = (state == dcache_pkg::MISS);
    assign o_mem_rd.addr  = {i_req.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

    // array output is steady here since nothing writes the set meanwhile
    assign o_mem_wr_valid = (state == dcache_pkg::WRITE_BACK);
    assign o_mem_wr_addr  = {i_way_rd[victim].tag, index, {`DC_OFFSET_W{1'b0}}};
    assign o_mem_wr_data  = i_way_rd[victim].line;

endmodule

// ==== verilog/dcache_load_align.sv ====
`include "dcache_macros.svh"

module dcache_load_align (
    input  dcache_pkg::dcache_req_t i_req,
    input  dcache_pkg::way_rd_t     i_way_rd [`DC_WAYS],
    input  dcache_pkg::line_t       i_refill_line,
    input  logic                    i_use_refill,
    output logic [31:0]             o_rdata
);

    dcache_pkg::line_t line;
    logic [31:0]       word;
    logic [31:0]       shifted;   // addressed byte or half at bit 0

    always_comb begin
        line = i_way_rd[0].line;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (i_way_rd[w].hit) begin
                line = i_way_rd[w].line;
            end
        end
        if (i_use_refill) begin
            line = i_refill_line;   // miss answered from the return buffer
        end
    end

    assign word    = line[i_req.addr[`DC_OFFSET_W-1:2]*32 +: 32];
    assign shifted = word >> {i_req.addr[1:0], 3'b000};

    always_comb begin
        case (i_req.size)
            dcache_pkg::SIZE_BYTE: begin
                o_rdata = {{24{i_req.sign & shifted[7]}}, shifted[7:0]};
            end
            dcache_pkg::SIZE_HALF: begin
                o_rdata = {{16{i_req.sign & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                o_rdata = word;
            end
        endcase
    end

endmodule

// ==== verilog/dcache_top.sv ====
`include "dcache_macros.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_valid,
    input  dcache_pkg::dcache_req_t i_req,
    output logic                   o_accept,
    output logic                   o_done,
    output logic [31:0]            o_rdata,
    output dcache_pkg::mem_rd_t    o_mem_rd,
    input  logic                   i_mem_rd_ready,
    input  dcache_pkg::line_t      i_mem_rd_data,
    output logic                   o_mem_wr_valid,
    output logic [`DC_ADDR_W-1:0]  o_mem_wr_addr,
    output dcache_pkg::line_t      o_mem_wr_data,
    input  logic                   i_mem_wr_ready
);

    dcache_pkg::dcache_req_t held_req;
    dcache_pkg::store_t      store;
    dcache_pkg::way_rd_t     way_rd [`DC_WAYS];
    dcache_pkg::way_wr_t     way_wr [`DC_WAYS];
    dcache_pkg::line_t       refill_line;
    logic [`DC_INDEX_W-1:0]  rd_index;
    logic                    take;
    logic                    use_refill;

    dcache_req_buf u_req_buf (
        .clk     (clk),
        .rstn    (rstn),
        .i_req   (i_req),
        .i_take  (take),
        .o_req   (held_req),
        .o_store (store)
    );

    for (genvar g = 0; g < `DC_WAYS; g++) begin : g_way
        dcache_way u_way (
            .clk        (clk),
            .rstn       (rstn),
            .i_rd_index (rd_index),
            .i_tag      (held_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W]),
            .i_wr       (way_wr[g]),
            .o_rd       (way_rd[g])
        );
    end

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_valid        (i_valid),
        .i_new_index    (i_req.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .i_req          (held_req),
        .i_store        (store),
        .i_way_rd       (way_rd),
        .o_take         (take),
        .o_accept       (o_accept),
        .o_rd_index     (rd_index),
        .o_way_wr       (way_wr),
        .o_use_refill   (use_refill),
        .o_refill_line  (refill_line),
        .o_done         (o_done),
        .o_mem_rd       (o_mem_rd),
        .i_mem_rd_ready (i_mem_rd_ready),
        .i_mem_rd_data  (i_mem_rd_data),
        .o_mem_wr_valid (o_mem_wr_valid),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_data  (o_mem_wr_data),
        .i_mem_wr_ready (i_mem_wr_ready)
    );

    dcache_load_align u_load_align (
        .i_req         (held_req),
        .i_way_rd      (way_rd),
        .i_refill_line (refill_line),
        .i_use_refill  (use_refill),
        .o_rdata       (o_rdata)
    );

endmodule

// ==== test/dcache_mem_model.sv ====
`include "dcache_macros.svh"

module dcache_mem_model (
    input  logic                  clk,
    input  dcache_pkg::mem_rd_t   i_rd,
    output logic                  o_rd_ready,
    output dcache_pkg::line_t     o_rd_data,
    input  logic                  i_wr_valid,
    input  logic [`DC_ADDR_W-1:0] i_wr_addr,
    input  dcache_pkg::line_t     i_wr_data,
    output logic                  o_wr_ready,
    output int                    o_wb_count,
    output logic [`DC_ADDR_W-1:0] o_wb_addr,
    output dcache_pkg::line_t     o_wb_line
);

    localparam int BYTES = `DC_LINE_W / 8;

    logic [7:0] mem [1 << 14];   // whole test window
    int         rd_wait;
    int         wr_wait;

    // hash of the full address
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24];
    endfunction

    function automatic dcache_pkg::line_t read_line(input logic [13:0] base);
        dcache_pkg::line_t l;
        for (int b = 0; b < BYTES; b++) begin
            l[b*8 +: 8] = mem[base + 14'(b)];
        end
        return l;
    endfunction

    initial begin
        o_rd_ready = 1'b0;
        o_rd_data  = '0;
        o_wr_ready = 1'b0;
        o_wb_count = 0;
        o_wb_addr  = '0;
        o_wb_line  = '0;
        rd_wait    = -1;
        wr_wait    = -1;
        for (int i = 0; i < (1 << 14); i++) begin
            mem[14'(i)] = fill_byte(32'(i));
        end
        forever begin
            @(negedge clk);
            if (i_wr_valid && o_wr_ready) begin   // transfer at the coming edge
                for (int b = 0; b < BYTES; b++) begin
                    mem[i_wr_addr[13:0] + 14'(b)] = i_wr_data[b*8 +: 8];
                end
                o_wb_count++;
                o_wb_addr = i_wr_addr;
                o_wb_line = i_wr_data;
            end
            @(posedge clk);
            #1;
            o_rd_ready = 1'b0;
            o_wr_ready = 1'b0;
            if (!i_rd.valid) begin
                rd_wait = -1;
            end else begin
                if (rd_wait < 0) rd_wait = int'($urandom_range(4, 0));
                if (rd_wait == 0) begin
                    o_rd_ready = 1'b1;
                    o_rd_data  = read_line(i_rd.addr[13:0]);
                end
                rd_wait--;
            end
            if (!i_wr_valid) begin
                wr_wait = -1;
            end else begin
                if (wr_wait < 0) wr_wait = int'($urandom_range(4, 0));
                if (wr_wait == 0) o_wr_ready = 1'b1;
                wr_wait--;
            end
        end
    end

endmodule

// ==== test/dcache_asserts.sv ====
`include "dcache_macros.svh"

module dcache_asserts (
    input logic                      clk,
    input logic                      rstn,
    input dcache_pkg::dcache_state_e i_state,
    input logic                      i_accept,
    input logic                      i_done,
    input dcache_pkg::mem_rd_t       i_mem_rd,
    input logic                      i_mem_rd_ready,
    input logic                      i_mem_wr_valid,
    input logic [`DC_ADDR_W-1:0]     i_mem_wr_addr,
    input dcache_pkg::line_t         i_mem_wr_data,
    input logic                      i_mem_wr_ready
);

    int violations = 0;   // failed rule count

    a_rd_held: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_rd.valid && !i_mem_rd_ready |=> i_mem_rd.valid && $stable(i_mem_rd.addr))
        else begin
            violations++;
            $error("memory read request dropped or changed before ready");
        end

    a_wr_held: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_wr_valid && !i_mem_wr_ready |=>
            i_mem_wr_valid && $stable(i_mem_wr_addr) && $stable(i_mem_wr_data))
        else begin
            violations++;
            $error("memory write dropped or changed before ready");
        end

    a_idle_done: assert property (@(posedge clk) disable iff (!rstn)
        i_state == dcache_pkg::IDLE |-> !i_done)
        else begin
            violations++;
            $error("done raised while idle");
        end

    a_busy_accept: assert property (@(posedge clk) disable iff (!rstn)
        (i_state == dcache_pkg::WRITE_BACK || i_state == dcache_pkg::MISS ||
         i_state == dcache_pkg::REFILL) |-> !i_accept)
        else begin
            violations++;
            $error("request accepted while a miss is in progress");
        end

    // one reset edge is enough to clear the FSM
    a_reset_quiet: assert property (@(posedge clk)
        !rstn |=> !i_mem_rd.valid && !i_mem_wr_valid)
        else begin
            violations++;
            $error("memory request raised during reset");
        end

endmodule

// ==== test/dcache_tb.sv ====
`include "dcache_macros.svh"

module dcache_tb;

    localparam int MEM_BYTES = 1 << 14;   // tags 0..3 over sets 0..3
    localparam int TIMEOUT   = 200;

    typedef struct packed {
        logic        check;   // compare the data of a read
        logic        hit;     // must answer the cycle after acceptance
        int          cycle;
        logic [31:0] addr;
        logic [31:0] value;
    } expect_t;

    logic                    clk;
    logic                    rstn;
    logic                    i_valid;
    dcache_pkg::dcache_req_t req;
    logic                    accept;
    logic                    done;
    logic [31:0]             rdata;
    dcache_pkg::mem_rd_t     mem_rd;
    logic                    mem_rd_ready;
    dcache_pkg::line_t       mem_rd_data;
    logic                    mem_wr_valid;
    logic [`DC_ADDR_W-1:0]   mem_wr_addr;
    dcache_pkg::line_t       mem_wr_data;
    logic                    mem_wr_ready;
    int                      wb_count;
    logic [`DC_ADDR_W-1:0]   wb_addr;
    dcache_pkg::line_t       wb_line;

    logic [7:0] golden [MEM_BYTES];
    bit         used [MEM_BYTES/4];   // word addresses touched
    expect_t    expect_q [$];
    int         cycle = 0;

    dcache_top UUT (
        .clk            (clk),
        .rstn           (rstn),
        .i_valid        (i_valid),
        .i_req          (req),
        .o_accept       (accept),
        .o_done         (done),
        .o_rdata        (rdata),
        .o_mem_rd       (mem_rd),
        .i_mem_rd_ready (mem_rd_ready),
        .i_mem_rd_data  (mem_rd_data),
        .o_mem_wr_valid (mem_wr_valid),
        .o_mem_wr_addr  (mem_wr_addr),
        .o_mem_wr_data  (mem_wr_data),
        .i_mem_wr_ready (mem_wr_ready)
    );

    dcache_mem_model u_mem (
        .clk        (clk),
        .i_rd       (mem_rd),
        .o_rd_ready (mem_rd_ready),
        .o_rd_data  (mem_rd_data),
        .i_wr_valid (mem_wr_valid),
        .i_wr_addr  (mem_wr_addr),
        .i_wr_data  (mem_wr_data),
        .o_wr_ready (mem_wr_ready),
        .o_wb_count (wb_count),
        .o_wb_addr  (wb_addr),
        .o_wb_line  (wb_line)
    );

    bind dcache_ctrl dcache_asserts u_asserts (
        .clk            (clk),
        .rstn           (rstn),
        .i_state        (state),
        .i_accept       (o_accept),
        .i_done         (o_done),
        .i_mem_rd       (o_mem_rd),
        .i_mem_rd_ready (i_mem_rd_ready),
        .i_mem_wr_valid (o_mem_wr_valid),
        .i_mem_wr_addr  (o_mem_wr_addr),
        .i_mem_wr_data  (o_mem_wr_data),
        .i_mem_wr_ready (i_mem_wr_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_with(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // same hash as the memory model's initial contents
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        return h[31:24];
    endfunction

    function automatic logic [31:0] expected_load(input logic [13:0] a,
                                                  input dcache_pkg::dcache_size_e size,
                                                  input logic sign);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = golden[a];
        b1 = golden[a + 14'd1];
        case (size)
            dcache_pkg::SIZE_BYTE: return {{24{sign & b0[7]}}, b0};
            dcache_pkg::SIZE_HALF: return {{16{sign & b1[7]}}, b1, b0};
            default:               return {golden[a + 14'd3], golden[a + 14'd2], b1, b0};
        endcase
    endfunction

    function automatic void apply_store(input logic [13:0] a,
                                        input dcache_pkg::dcache_size_e size,
                                        input logic [31:0] wdata);
        int n;
        n = (size == dcache_pkg::SIZE_BYTE) ? 1 : (size == dcache_pkg::SIZE_HALF) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            golden[a + 14'(b)] = wdata[b*8 +: 8];
        end
    endfunction

    function automatic dcache_pkg::line_t golden_line(input logic [13:0] base);
        dcache_pkg::line_t l;
        for (int b = 0; b < `DC_LINE_W / 8; b++) begin
            l[b*8 +: 8] = golden[base + 14'(b)];
        end
        return l;
    endfunction

    // hold the request until accepted and take its expectation from golden then
    task automatic issue(input logic [31:0] addr, input dcache_pkg::dcache_op_e op,
                         input dcache_pkg::dcache_size_e size, input logic sign,
                         input logic [31:0] wdata, input logic hit);
        int      waited;
        expect_t e;
        req.addr  = addr;
        req.op    = op;
        req.size  = size;
        req.sign  = sign;
        req.wdata = wdata;
        i_valid   = 1'b1;
        waited    = 0;
        @(negedge clk);
        while (!accept) begin
            waited++;
            assert (waited < TIMEOUT) else stop_with("a request was never accepted");
            @(negedge clk);
        end
        e.check = (op == dcache_pkg::OP_READ);
        e.hit   = hit;
        e.cycle = cycle;
        e.addr  = addr;
        e.value = e.check ? expected_load(addr[13:0], size, sign) : '0;
        expect_q.push_back(e);
        if (op == dcache_pkg::OP_WRITE) apply_store(addr[13:0], size, wdata);
        used[addr[13:2]] = 1'b1;
        @(posedge clk);
        #1;
        i_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else stop_with("responses stopped arriving");
        end
        @(posedge clk);
        #1;
    endtask

    initial begin : compare
        expect_t e;
        forever begin
            @(negedge clk);
            assert (UUT.u_ctrl.u_asserts.violations == 0)
                else stop_with("a bound protocol assertion failed");
            if (rstn && done) begin
                assert (expect_q.size() != 0)
                    else stop_with("done pulsed with no request outstanding");
                e = expect_q.pop_front();
                if (e.check) begin
                    assert (rdata == e.value)
                        else stop_with($sformatf("FAIL @%0t: load %08h gave %08h, expected %08h",
                                                 $time, e.addr, rdata, e.value));
                end
                if (e.hit) begin
                    assert (cycle == e.cycle + 1)
                        else stop_with($sformatf("FAIL @%0t: hit on %08h answered late",
                                                 $time, e.addr));
                end
            end
            if (mem_wr_valid && mem_wr_ready) begin   // write-back at the coming edge
                assert (mem_wr_addr[`DC_OFFSET_W-1:0] == '0 && mem_wr_addr[31:14] == '0)
                    else stop_with($sformatf("FAIL @%0t: bad write-back address %08h",
                                             $time, mem_wr_addr));
                assert (mem_wr_data == golden_line(mem_wr_addr[13:0]))
                    else stop_with($sformatf("FAIL @%0t: write-back data wrong for %08h",
                                             $time, mem_wr_addr));
            end
        end
    end

    initial begin : stimulus
        int                       tag;
        int                       idx;
        int                       off;
        int                       nb;
        int                       wb_before;
        int                       burst_start;
        logic [31:0]              addr;
        dcache_pkg::dcache_op_e   op;
        dcache_pkg::dcache_size_e size;
        void'($urandom(63823));
        rstn    = 1'b0;
        i_valid = 1'b0;
        req     = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            golden[14'(i)] = fill_byte(32'(i));
        end
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        @(negedge clk);
        assert (!done && !mem_rd.valid && !mem_wr_valid && accept)
            else stop_with($sformatf("FAIL @%0t: outputs not quiet after reset", $time));
        @(posedge clk);
        #1;

        // read miss, then hits streaming behind it
        issue(32'h0000_0010, dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'b0, '0, 1'b0);
        issue(32'h0000_0014, dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'b0, '0, 1'b1);
        burst_start = cycle;
        for (int w = 0; w < 16; w++) begin
            issue(32'(w * 4), dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'b0, '0, 1'b1);
        end
        assert (cycle == burst_start + 16)
            else stop_with($sformatf("FAIL @%0t: 16 back-to-back hits took %0d cycles",
                                     $time, cycle - burst_start));
        drain();

        // store miss, store hits, then every load size and sign
        issue(32'h0000_0044, dcache_pkg::OP_WRITE, dcache_pkg::SIZE_WORD, 1'b0,
              32'h8001_7ff0, 1'b0);
        issue(32'h0000_0045, dcache_pkg::OP_WRITE, dcache_pkg::SIZE_BYTE, 1'b0,
              32'h0000_00c3, 1'b0);
        issue(32'h0000_0046, dcache_pkg::OP_WRITE, dcache_pkg::SIZE_HALF, 1'b0,
              32'h0000_9a5b, 1'b0);
        issue(32'h0000_0082, dcache_pkg::OP_WRITE, dcache_pkg::SIZE_HALF, 1'b0,
              32'h0000_f00d, 1'b0);
        for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < 4; b++) begin
                issue(32'h44 + 32'(b), dcache_pkg::OP_READ, dcache_pkg::SIZE_BYTE, 1'(s), '0, 1'b1);
            end
            issue(32'h44, dcache_pkg::OP_READ, dcache_pkg::SIZE_HALF, 1'(s), '0, 1'b1);
            issue(32'h46, dcache_pkg::OP_READ, dcache_pkg::SIZE_HALF, 1'(s), '0, 1'b1);
            issue(32'h44, dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'(s), '0, 1'b1);
            issue(32'h82, dcache_pkg::OP_READ, dcache_pkg::SIZE_HALF, 1'(s), '0, 1'b1);
            issue(32'h80, dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'(s), '0, 1'b1);
        end
        drain();

        // three lines in set 3 with a dirty victim and then a clean one
        issue(32'h0000_10c4, dcache_pkg::OP_WRITE, dcache_pkg::SIZE_WORD, 1'b0,
              32'hdead_beef, 1'b0);
        issue(32'h0000_20c0, dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'b0, '0, 1'b0);
        drain();
        wb_before = wb_count;
        issue(32'h0000_30c0, dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'b0, '0, 1'b0);
        drain();
        assert (wb_count == wb_before + 1 && wb_addr == 32'h0000_10c0 &&
                wb_line == golden_line(14'h10c0))
            else stop_with($sformatf("FAIL @%0t: dirty eviction gave %0d write-backs at %08h",
                                     $time, wb_count - wb_before, wb_addr));
        wb_before = wb_count;
        issue(32'h0000_10c8, dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'b0, '0, 1'b0);
        drain();
        assert (wb_count == wb_before)
            else stop_with($sformatf("FAIL @%0t: clean eviction wrote back", $time));

        // random mix over 16 lines in 4 sets
        for (int n = 0; n < 600; n++) begin
            tag  = int'($urandom_range(3, 0));
            idx  = int'($urandom_range(3, 0));
            size = dcache_pkg::dcache_size_e'(2'($urandom_range(2, 0)));
            op   = dcache_pkg::dcache_op_e'(1'($urandom_range(1, 0)));
            nb   = 1 << int'(size);
            off  = int'($urandom_range(63, 0)) & ~(nb - 1);
            addr = 32'(tag * 4096 + idx * 64 + off);
            issue(addr, op, size, 1'($urandom_range(1, 0)), $urandom, 1'b0);
        end
        drain();

        for (int w = 0; w < MEM_BYTES / 4; w++) begin
            if (used[12'(w)]) begin
                issue(32'(w * 4), dcache_pkg::OP_READ, dcache_pkg::SIZE_WORD, 1'b0, '0, 1'b0);
            end
        end
        drain();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== dcache.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_req_buf.sv
verilog/dcache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache_load_align.sv
verilog/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_asserts.sv
test/dcache_tb.sv

// ==== Makefile ====
TOP = dcache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f dcache.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
